//--- rtl/blink_io_pkg.sv
package blink_io_pkg;

  // I/O port map, low byte of the Z80 address
  localparam logic [7:0] IO_COM  = 8'hB0;
  localparam logic [7:0] IO_INT  = 8'hB1; // INT on write
  localparam logic [7:0] IO_STA  = 8'hB1; // STA on read
  localparam logic [7:0] IO_KBD  = 8'hB2;
  localparam logic [7:0] IO_TACK = 8'hB4;
  localparam logic [7:0] IO_TMK  = 8'hB5; // TMK on write
  localparam logic [7:0] IO_TSTA = 8'hB5; // TSTA on read
  localparam logic [7:0] IO_ACK  = 8'hB6;

  // LCD base registers, high bits ride on the address high byte
  localparam logic [7:0] IO_PB0 = 8'h70;
  localparam logic [7:0] IO_PB1 = 8'h71;
  localparam logic [7:0] IO_PB2 = 8'h72;
  localparam logic [7:0] IO_PB3 = 8'h73;
  localparam logic [7:0] IO_SBR = 8'h74;

  // Segment registers on write, TIM0..TIM3 on read
  localparam logic [7:0] IO_SR0  = 8'hD0;
  localparam logic [7:0] IO_SR1  = 8'hD1;
  localparam logic [7:0] IO_SR2  = 8'hD2;
  localparam logic [7:0] IO_SR3  = 8'hD3;
  localparam logic [7:0] IO_TIM4 = 8'hD4;
  localparam logic [7:0] IO_UIT  = 8'hE5; // UART status, reads zero

  typedef logic [7:0] io_data_t;

  localparam int COM_LCDON  = 0;
  localparam int COM_RAMS   = 2;
  localparam int COM_RESTIM = 4;
  localparam int INT_GINT   = 0;
  localparam int INT_TIME   = 1;
  localparam int INT_FLAP   = 5;
  localparam int ACK_KEY    = 2;
  localparam int ACK_FLAP   = 5;

  localparam int TSTA_W = 3; // Tick, second, minute
  localparam int PB0_W  = 13;
  localparam int PB1_W  = 10;
  localparam int PB2_W  = 9;
  localparam int PB3_W  = 11;
  localparam int SBR_W  = 11;

  localparam int TICK_DIV_DEFAULT = 49152;
  localparam int TIM0_LAST        = 199; // 200 ticks of 5 ms
  localparam int TIM1_LAST        = 59;
  localparam int TIMM_W           = 21;

endpackage

//--- rtl/blink_mem_pkg.sv
package blink_mem_pkg;

  localparam int PADDR_W = 22; // 4 MB physical space
  localparam int BANK_W  = 8;
  localparam int OFFS_W  = 14; // 16 KB bank

  typedef logic [PADDR_W-1:0] paddr_t;
  typedef logic [15:0]        zaddr_t;
  typedef logic [BANK_W-1:0]  bank_t;

  // Slot 0 splits into ROM and RAM halves, top three bits
  localparam logic [2:0] SLOT_ROM0 = 3'b000;
  localparam logic [2:0] SLOT_RAM0 = 3'b001;

  // Slots 1 to 3, top two bits
  localparam logic [1:0] SLOT1 = 2'b01;
  localparam logic [1:0] SLOT2 = 2'b10;
  localparam logic [1:0] SLOT3 = 2'b11;

endpackage

//--- rtl/blink_mmu.sv
`timescale 1ns/1ps

module blink_mmu (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  clk_ena,
  input  blink_mem_pkg::zaddr_t z80_addr,
  input  logic                  z80_mrq_n,
  input  logic                  z80_crd_n,
  input  blink_mem_pkg::bank_t  sr0,
  input  blink_mem_pkg::bank_t  sr1,
  input  blink_mem_pkg::bank_t  sr2,
  input  blink_mem_pkg::bank_t  sr3,
  input  logic                  com_rams,
  input  blink_mem_pkg::paddr_t lcd_addr,
  output logic [2:0]            clk_ph,
  output logic                  zac,
  output logic                  ext_oe_n,
  output logic                  ext_we_n,
  output logic                  rom_cs_n,
  output logic                  ram_cs_n,
  output logic [3:1]            ext_cs_n,
  output blink_mem_pkg::paddr_t ext_addr
);
  import blink_mem_pkg::*;

  paddr_t za; // Translated Z80 address

  // Active-low selects {cs3, cs2, cs1, ram, rom} for an address
  function automatic logic [4:0] slot_cs(input paddr_t a, input logic sel_n);
    logic [4:0] cs;
    cs = 5'b11111;
    case (a[PADDR_W-1 -: 3])
      SLOT_ROM0: cs[0] = sel_n;
      SLOT_RAM0: cs[1] = sel_n;
      default: ;
    endcase
    case (a[PADDR_W-1 -: 2])
      SLOT1: cs[2] = sel_n;
      SLOT2: cs[3] = sel_n;
      SLOT3: cs[4] = sel_n;
      default: ;
    endcase
    return cs;
  endfunction

  assign zac = clk_ph[2]; // Z80 access phase

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      clk_ph <= 3'b001;
    end else if (clk_ena) begin
      clk_ph <= {clk_ph[1:0], clk_ph[2]}; // Rotate one-hot
    end
  end

  // Segment translation, sampled at phase 0
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      za <= '0;
    end else if (clk_ena && clk_ph[0]) begin
      casez (z80_addr[15:13])
        3'b000: za <= {2'b00, com_rams, 6'b0, z80_addr[12:0]}; // Bank 00 or 20
        3'b001: za <= {sr0[7:1], 1'b0, sr0[0], z80_addr[12:0]}; // Even bank half
        3'b01?: za <= {sr1, z80_addr[OFFS_W-1:0]};
        3'b10?: za <= {sr2, z80_addr[OFFS_W-1:0]};
        default: za <= {sr3, z80_addr[OFFS_W-1:0]};
      endcase
    end
  end

  // Bus runs on every clock, Z80 slot once per rotation
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      ext_oe_n <= 1'b1;
      ext_we_n <= 1'b1;
      {ext_cs_n, ram_cs_n, rom_cs_n} <= '1;
      ext_addr <= '0;
    end else if (zac) begin
      ext_oe_n <= z80_mrq_n | z80_crd_n;
      ext_we_n <= z80_mrq_n | ~z80_crd_n;
      {ext_cs_n, ram_cs_n, rom_cs_n} <= slot_cs(za, z80_mrq_n);
      ext_addr <= za;
    end else begin
      // LCD fetch slot, always a read
      ext_oe_n <= 1'b0;
      ext_we_n <= 1'b1;
      {ext_cs_n, ram_cs_n, rom_cs_n} <= slot_cs(lcd_addr, 1'b0);
      ext_addr <= lcd_addr;
    end
  end

endmodule

//--- rtl/blink_regs.sv
`timescale 1ns/1ps

module blink_regs (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic                                  clk_ena,
  input  logic                                  zac,
  input  logic                                  z80_ior_n,
  input  logic                                  z80_crd_n,
  input  blink_mem_pkg::zaddr_t                 z80_addr,
  input  blink_io_pkg::io_data_t                z80_wdata,
  input  blink_io_pkg::io_data_t                sta,
  input  blink_io_pkg::io_data_t                kbd,
  input  logic [blink_io_pkg::TSTA_W-1:0]       tsta,
  input  logic [7:0]                            tim0,
  input  logic [5:0]                            tim1,
  input  logic [blink_io_pkg::TIMM_W-1:0]       timm,
  output blink_io_pkg::io_data_t                z80_rdata,
  output blink_mem_pkg::bank_t                  sr0,
  output blink_mem_pkg::bank_t                  sr1,
  output blink_mem_pkg::bank_t                  sr2,
  output blink_mem_pkg::bank_t                  sr3,
  output logic                                  com_rams,
  output logic                                  com_lcdon,
  output logic                                  com_restim,
  output logic [blink_io_pkg::PB0_W-1:0]        lcd_pb0,
  output logic [blink_io_pkg::PB1_W-1:0]        lcd_pb1,
  output logic [blink_io_pkg::PB2_W-1:0]        lcd_pb2,
  output logic [blink_io_pkg::PB3_W-1:0]        lcd_pb3,
  output logic [blink_io_pkg::SBR_W-1:0]        lcd_sbr,
  output logic [6:0]                            int_en,
  output logic [blink_io_pkg::TSTA_W-1:0]       tmk,
  output logic [blink_io_pkg::TSTA_W-1:0]       tsta_clr,
  output logic                                  key_ack,
  output logic                                  flap_ack
);
  import blink_io_pkg::*;

  logic [7:0] port;   // I/O address low byte
  logic       reg_wr;
  logic       reg_rd;
  io_data_t   com;
  io_data_t   cdo;    // Read buffer
  io_data_t   cdi;    // Z80 data latch

  assign port   = z80_addr[7:0];
  assign reg_wr = clk_ena & zac & ~z80_ior_n & z80_crd_n;
  assign reg_rd = clk_ena & zac & ~z80_ior_n & ~z80_crd_n;

  assign com_lcdon  = com[COM_LCDON];
  assign com_rams   = com[COM_RAMS];
  assign com_restim = com[COM_RESTIM];

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      com      <= '0;
      int_en   <= '0;
      sr0      <= '0;
      sr1      <= '0;
      sr2      <= '0;
      sr3      <= '0;
      lcd_pb0  <= '0;
      lcd_pb1  <= '0;
      lcd_pb2  <= '0;
      lcd_pb3  <= '0;
      lcd_sbr  <= '0;
      tmk      <= '0;
      tsta_clr <= '0;
      key_ack  <= 1'b0;
      flap_ack <= 1'b0;
    end else if (clk_ena) begin
      tsta_clr <= '0; // Acks are single pulses
      key_ack  <= 1'b0;
      flap_ack <= 1'b0;
      if (reg_wr) begin
        case (port)
          IO_COM:  com <= z80_wdata;
          IO_INT:  int_en <= z80_wdata[6:0]; // KWAIT bit ignored
          IO_SR0:  sr0 <= z80_wdata;
          IO_SR1:  sr1 <= z80_wdata;
          IO_SR2:  sr2 <= z80_wdata;
          IO_SR3:  sr3 <= z80_wdata;
          IO_PB0:  lcd_pb0 <= {z80_addr[PB0_W-1:8], z80_wdata};
          IO_PB1:  lcd_pb1 <= {z80_addr[PB1_W-1:8], z80_wdata};
          IO_PB2:  lcd_pb2 <= {z80_addr[PB2_W-1:8], z80_wdata};
          IO_PB3:  lcd_pb3 <= {z80_addr[PB3_W-1:8], z80_wdata};
          IO_SBR:  lcd_sbr <= {z80_addr[SBR_W-1:8], z80_wdata};
          IO_TACK: tsta_clr <= z80_wdata[TSTA_W-1:0];
          IO_TMK:  tmk <= z80_wdata[TSTA_W-1:0];
          IO_ACK: begin
            key_ack  <= z80_wdata[ACK_KEY];
            flap_ack <= z80_wdata[ACK_FLAP];
          end
          default: ;
        endcase
      end
    end
  end

  // Read buffer, loaded by port
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      cdo <= '0;
    end else if (reg_rd) begin
      case (port)
        IO_STA:  cdo <= sta;
        IO_KBD:  cdo <= kbd;
        IO_TSTA: cdo <= io_data_t'(tsta);
        IO_SR0:  cdo <= tim0;              // TIM0 5 ms ticks
        IO_SR1:  cdo <= io_data_t'(tim1);  // TIM1 seconds
        IO_SR2:  cdo <= timm[7:0];         // TIM2 minutes
        IO_SR3:  cdo <= timm[15:8];
        IO_TIM4: cdo <= io_data_t'(timm[TIMM_W-1:16]);
        IO_UIT:  cdo <= '0;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      cdi <= '0;
    end else if (zac) begin
      cdi <= z80_wdata;
    end
  end

  assign z80_rdata = !z80_ior_n ? cdo : cdi; // Buffer only during I/O cycles

endmodule

//--- rtl/blink_top.sv
`timescale 1ns/1ps

module blink_top #(
  parameter int TICK_DIV = blink_io_pkg::TICK_DIV_DEFAULT
) (
  input  logic                           rst,
  input  logic                           clk,
  input  logic                           clk_ena,   // 10 MHz equivalent
  output logic [2:0]                     clk_ph,
  input  logic                           z80_hlt_n, // HALT, standby not modelled
  input  logic                           z80_crd_n,
  input  logic                           z80_cm1_n, // M1, not decoded
  input  logic                           z80_mrq_n,
  input  logic                           z80_ior_n,
  input  blink_mem_pkg::zaddr_t          z80_addr,
  input  blink_io_pkg::io_data_t         z80_wdata,
  output blink_io_pkg::io_data_t         z80_rdata,
  output logic                           z80_nmi_n,
  output logic                           z80_int_n,
  input  blink_mem_pkg::paddr_t          lcd_addr,
  output logic                           lcd_on,
  output logic [blink_io_pkg::PB0_W-1:0] lcd_pb0,
  output logic [blink_io_pkg::PB1_W-1:0] lcd_pb1,
  output logic [blink_io_pkg::PB2_W-1:0] lcd_pb2,
  output logic [blink_io_pkg::PB3_W-1:0] lcd_pb3,
  output logic [blink_io_pkg::SBR_W-1:0] lcd_sbr,
  output logic                           ext_oe_n,
  output logic                           ext_we_n,
  output logic                           ram_cs_n,
  output logic                           rom_cs_n,
  output logic [3:1]                     ext_cs_n,
  output blink_mem_pkg::paddr_t          ext_addr,
  input  logic [63:0]                    kbmat,
  output blink_io_pkg::io_data_t         kbdval,
  output logic                           kbds,
  output logic                           key,
  output logic                           t_1s,
  output logic                           t_5ms,
  input  logic                           flp        // Flap open
);
  import blink_io_pkg::*;
  import blink_mem_pkg::*;

  logic              zac;
  bank_t             sr0, sr1, sr2, sr3;
  logic              com_rams;
  logic              com_restim;
  logic [6:0]        int_en;
  logic [TSTA_W-1:0] tmk, tsta_clr, tsta, tick_evt;
  logic              key_ack, flap_ack;
  io_data_t          sta, kbd;
  logic [7:0]        tim0;
  logic [5:0]        tim1;
  logic [TIMM_W-1:0] timm;

  blink_mmu u_mmu (
    .clk(clk), .rst(rst), .clk_ena(clk_ena),
    .z80_addr(z80_addr), .z80_mrq_n(z80_mrq_n), .z80_crd_n(z80_crd_n),
    .sr0(sr0), .sr1(sr1), .sr2(sr2), .sr3(sr3),
    .com_rams(com_rams), .lcd_addr(lcd_addr),
    .clk_ph(clk_ph), .zac(zac),
    .ext_oe_n(ext_oe_n), .ext_we_n(ext_we_n),
    .rom_cs_n(rom_cs_n), .ram_cs_n(ram_cs_n),
    .ext_cs_n(ext_cs_n), .ext_addr(ext_addr)
  );

  blink_regs u_regs (
    .clk(clk), .rst(rst), .clk_ena(clk_ena), .zac(zac),
    .z80_ior_n(z80_ior_n), .z80_crd_n(z80_crd_n),
    .z80_addr(z80_addr), .z80_wdata(z80_wdata),
    .sta(sta), .kbd(kbd), .tsta(tsta),
    .tim0(tim0), .tim1(tim1), .timm(timm),
    .z80_rdata(z80_rdata),
    .sr0(sr0), .sr1(sr1), .sr2(sr2), .sr3(sr3),
    .com_rams(com_rams), .com_lcdon(lcd_on), .com_restim(com_restim),
    .lcd_pb0(lcd_pb0), .lcd_pb1(lcd_pb1), .lcd_pb2(lcd_pb2),
    .lcd_pb3(lcd_pb3), .lcd_sbr(lcd_sbr),
    .int_en(int_en), .tmk(tmk), .tsta_clr(tsta_clr),
    .key_ack(key_ack), .flap_ack(flap_ack)
  );

  rtc_timer #(.TICK_DIV(TICK_DIV)) u_rtc (
    .clk(clk), .rst(rst), .clk_ena(clk_ena),
    .flp(flp), .com_restim(com_restim),
    .tim0(tim0), .tim1(tim1), .timm(timm), .tick_evt(tick_evt),
    .t_1s(t_1s), .t_5ms(t_5ms)
  );

  int_ctrl u_int (
    .clk(clk), .rst(rst), .clk_ena(clk_ena), .flp(flp),
    .tick_evt(tick_evt), .tmk(tmk), .tsta_clr(tsta_clr), .int_en(int_en),
    .key_ack(key_ack), .flap_ack(flap_ack),
    .tsta(tsta), .sta(sta), .kbds(kbds),
    .z80_int_n(z80_int_n), .z80_nmi_n(z80_nmi_n)
  );

  // Rows picked by the address high byte of IN A,(B2)
  kbd_matrix u_kbd (
    .kbmat(kbmat), .row_sel(z80_addr[15:8]),
    .kbd(kbd), .kbdval(kbdval), .key(key)
  );

endmodule

//--- rtl/int_ctrl.sv
`timescale 1ns/1ps

module int_ctrl (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              clk_ena,
  input  logic                              flp,
  input  logic [blink_io_pkg::TSTA_W-1:0]   tick_evt,
  input  logic [blink_io_pkg::TSTA_W-1:0]   tmk,
  input  logic [blink_io_pkg::TSTA_W-1:0]   tsta_clr,
  input  logic [6:0]                        int_en,
  input  logic                              key_ack,
  input  logic                              flap_ack,
  output logic [blink_io_pkg::TSTA_W-1:0]   tsta,
  output blink_io_pkg::io_data_t            sta,
  output logic                              kbds,
  output logic                              z80_int_n,
  output logic                              z80_nmi_n
);
  import blink_io_pkg::*;

  logic [TSTA_W-1:0] tsta_set;
  logic              flap_set; // Flap sampled on enabled clock
  logic              flps;
  logic              rtcs;     // Any unmasked timer status

  assign tsta_set = tick_evt & {TSTA_W{clk_ena}};

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      flap_set <= 1'b0;
    end else if (clk_ena) begin
      flap_set <= flp;
    end
  end

  status_latch #(.flag_t(logic [TSTA_W-1:0])) u_tsta (
    .clk     (clk),
    .rst     (rst),
    .set_req (tsta_set),
    .clr_req (tsta_clr),
    .q       (tsta)
  );

  // Key wake-up not modelled, set side stays idle
  status_latch #(.flag_t(logic)) u_kbds (
    .clk     (clk),
    .rst     (rst),
    .set_req (1'b0),
    .clr_req (key_ack),
    .q       (kbds)
  );

  status_latch #(.flag_t(logic)) u_flps (
    .clk     (clk),
    .rst     (rst),
    .set_req (flap_set),
    .clr_req (flap_ack),
    .q       (flps)
  );

  assign rtcs = |(tsta & tmk);
  assign sta  = {flp, 1'b0, flps, 2'b00, kbds, 1'b0, rtcs};

  assign z80_int_n = ~(int_en[INT_GINT] &
                       ((rtcs & int_en[INT_TIME]) | (flps & int_en[INT_FLAP])));
  assign z80_nmi_n = ~flp; // Flap open forces NMI

endmodule

//--- rtl/kbd_matrix.sv
`timescale 1ns/1ps

module kbd_matrix (
  input  logic [63:0]            kbmat,
  input  logic [7:0]             row_sel, // Low bit selects a row
  output blink_io_pkg::io_data_t kbd,
  output blink_io_pkg::io_data_t kbdval,
  output logic                   key
);

  always_comb begin
    kbd    = '1;
    kbdval = '1; // All rows, debug view
    for (int r = 0; r < 8; r++) begin
      if (!row_sel[r]) begin
        kbd = kbd & ~kbmat[8*r +: 8];
      end
      kbdval = kbdval & ~kbmat[8*r +: 8];
    end
  end

  assign key = |kbmat;

endmodule

//--- rtl/rtc_timer.sv
`timescale 1ns/1ps

module rtc_timer #(
  parameter int TICK_DIV = blink_io_pkg::TICK_DIV_DEFAULT
) (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              clk_ena,
  input  logic                              flp,
  input  logic                              com_restim,
  output logic [7:0]                        tim0,
  output logic [5:0]                        tim1,
  output logic [blink_io_pkg::TIMM_W-1:0]   timm,
  output logic [blink_io_pkg::TSTA_W-1:0]   tick_evt,
  output logic                              t_1s,
  output logic                              t_5ms
);
  import blink_io_pkg::*;

  logic [15:0] tck; // Prescaler

  // Hard reset needs the flap open, so time survives a soft reset
  always_ff @(posedge clk) begin
    if ((rst && flp) || com_restim) begin
      tck      <= '0;
      tim0     <= '0;
      tim1     <= '0;
      timm     <= '0;
      tick_evt <= '0;
    end else if (clk_ena) begin
      tick_evt <= '0;
      if (tck == 16'(TICK_DIV)) begin
        tck         <= '0;
        tick_evt[0] <= 1'b1; // 5 ms
        if (tim0 == 8'(TIM0_LAST)) begin
          tim0        <= '0;
          tick_evt[1] <= 1'b1; // Second
          if (tim1 == 6'(TIM1_LAST)) begin
            tim1        <= '0;
            tick_evt[2] <= 1'b1; // Minute
            timm        <= timm + 1'b1;
          end else begin
            tim1 <= tim1 + 1'b1;
          end
        end else begin
          tim0 <= tim0 + 1'b1;
        end
      end else begin
        tck <= tck + 1'b1;
      end
    end
  end

  // Grey and flash strobes for the LCD
  assign t_1s  = tim0[7];
  assign t_5ms = tck[11];

endmodule

//--- rtl/status_latch.sv
`timescale 1ns/1ps

// Synchronous RS latch per bit
module status_latch #(
  parameter type flag_t = logic
) (
  input  logic  clk,
  input  logic  rst,
  input  flag_t set_req,
  input  flag_t clr_req,
  output flag_t q
);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      q <= '0;
    end else begin
      q <= (q | set_req) & ~clr_req; // Clear beats set
    end
  end

endmodule

//--- sim/tb_blink.sv
`timescale 1ns/1ps

module tb_blink;
  import blink_io_pkg::*;
  import blink_mem_pkg::*;

  localparam int TICK_DIV = 15;
  localparam int OP_WR = 0, OP_RD = 1, OP_MRD = 2, OP_WAIT = 3, OP_TIM = 4, OP_PORT = 5;
  localparam paddr_t LCD_ADDR = 22'h2ABCDE; // Lands in slot 2

  typedef struct {
    int          op;
    zaddr_t      addr;  // Cycle count for a wait
    io_data_t    data;  // Port selector for a pin check
    logic [63:0] kbmat;
    logic        flp;
    paddr_t      exp;
  } entry_t;

  logic rst, clk, clk_ena, z80_hlt_n, z80_crd_n, z80_cm1_n, z80_mrq_n, z80_ior_n, flp;
  zaddr_t z80_addr;
  io_data_t z80_wdata, z80_rdata, kbdval;
  paddr_t lcd_addr, ext_addr;
  logic [63:0] kbmat;
  logic [2:0] clk_ph;
  logic [3:1] ext_cs_n;
  logic z80_nmi_n, z80_int_n, lcd_on, ext_oe_n, ext_we_n, ram_cs_n, rom_cs_n;
  logic kbds, key, t_1s, t_5ms;
  logic [PB0_W-1:0] lcd_pb0;
  logic [PB1_W-1:0] lcd_pb1;
  logic [PB2_W-1:0] lcd_pb2;
  logic [PB3_W-1:0] lcd_pb3;
  logic [SBR_W-1:0] lcd_sbr;

  entry_t tbl[$];
  int errors = 0;
  int checks = 0;
  int rtc_edges = 0;         // Edges since reset release
  logic [31:0] lfsr_state = 32'd56;
  bit table_ready = 0;

  blink_top #(.TICK_DIV(TICK_DIV)) dut (.*);

  always #10 clk = ~clk;

  always @(posedge clk) begin
    if (!rst) rtc_edges <= rtc_edges + 1;
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  task automatic lfsr_bits(output logic [63:0] v);
    for (int i = 0; i < 64; i++) begin
      v[i] = lfsr_state[0];  // One step per bit
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  // Segment rule, bank times 16 KB plus offset
  function automatic paddr_t translate(input zaddr_t a, input bank_t s0, s1, s2, s3,
                                       input logic rams);
    paddr_t p;
    case (a[15:14])
      2'd0: begin
        if (!a[13]) p = (paddr_t'(rams ? 8'h20 : 8'h00) << 14) + a[12:0];
        else p = (paddr_t'(s0 & 8'hFE) << 14) + (paddr_t'(s0[0]) << 13) + a[12:0];
      end
      2'd1: p = (paddr_t'(s1) << 14) + a[13:0];
      2'd2: p = (paddr_t'(s2) << 14) + a[13:0];
      default: p = (paddr_t'(s3) << 14) + a[13:0];
    endcase
    return p;
  endfunction

  // Active low {cs3, cs2, cs1, ram, rom}
  function automatic logic [4:0] cs_expect(input paddr_t p);
    logic [4:0] cs;
    cs = 5'b11111;
    if (p[21:19] == 3'b000) cs[0] = 1'b0;
    if (p[21:19] == 3'b001) cs[1] = 1'b0;
    if (p[21:20] != 2'b00) cs[p[21:20] + 1] = 1'b0;
    return cs;
  endfunction

  function automatic paddr_t lcd_base(input zaddr_t a, input io_data_t d, input int w);
    return paddr_t'({a[15:8], d}) & ((paddr_t'(1) << w) - 1);
  endfunction

  // Row low in the selector pulls its pressed keys low
  function automatic io_data_t kbd_rows(input logic [63:0] km, input logic [7:0] rows);
    io_data_t v;
    v = 8'hFF;
    for (int r = 0; r < 8; r++) begin
      if (!rows[r]) v = v & ~km[8*r +: 8];
    end
    return v;
  endfunction

  function automatic paddr_t port_value(input int sel);
    case (sel)
      0: return paddr_t'(lcd_on);
      1: return paddr_t'(z80_int_n);
      2: return paddr_t'(z80_nmi_n);
      3: return paddr_t'(lcd_pb0);
      4: return paddr_t'(lcd_pb1);
      5: return paddr_t'(lcd_pb2);
      6: return paddr_t'(lcd_pb3);
      7: return paddr_t'(lcd_sbr);
      8: return paddr_t'(kbdval);
      9: return paddr_t'(key);
      default: return paddr_t'(kbds);
    endcase
  endfunction

  function automatic string port_name(input int sel);
    string names[11] = '{"lcd_on", "z80_int_n", "z80_nmi_n", "lcd_pb0", "lcd_pb1",
                         "lcd_pb2", "lcd_pb3", "lcd_sbr", "kbdval", "key", "kbds"};
    return names[sel];
  endfunction

  task automatic check_data(input string name, input io_data_t got, input io_data_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_addr(input string name, input paddr_t got, input paddr_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t ns: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_phase(input string name, input logic [2:0] got, input logic [2:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t ns: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic add(input int op, input zaddr_t a, input io_data_t d, input paddr_t exp,
                     input logic f = 1'b0, input logic [63:0] km = '0);
    entry_t e;
    e.op = op;
    e.addr = a;
    e.data = d;
    e.exp = exp;
    e.flp = f;
    e.kbmat = km;
    tbl.push_back(e);
  endtask

  task automatic build_table();
    bank_t s[4] = '{8'h41, 8'h22, 8'h83, 8'hC5};
    zaddr_t ma[5] = '{16'h1234, 16'h3456, 16'h5678, 16'h9ABC, 16'hDEF0};
    logic [7:0] rows[4] = '{8'hFE, 8'h7F, 8'hA5, 8'h00};
    logic [63:0] km;
    // LCD enable and base registers
    add(OP_WR, {8'h00, IO_COM}, 8'h01, '0);
    add(OP_PORT, '0, 8'd0, 22'd1);
    add(OP_WR, {8'h15, IO_PB0}, 8'h3C, '0);
    add(OP_WR, {8'hFF, IO_PB1}, 8'hA5, '0);
    add(OP_WR, {8'h01, IO_PB2}, 8'h5A, '0);
    add(OP_WR, {8'h06, IO_PB3}, 8'h81, '0);
    add(OP_WR, {8'h03, IO_SBR}, 8'hC3, '0);
    add(OP_PORT, '0, 8'd3, lcd_base({8'h15, IO_PB0}, 8'h3C, PB0_W));
    add(OP_PORT, '0, 8'd4, lcd_base({8'hFF, IO_PB1}, 8'hA5, PB1_W));
    add(OP_PORT, '0, 8'd5, lcd_base({8'h01, IO_PB2}, 8'h5A, PB2_W));
    add(OP_PORT, '0, 8'd6, lcd_base({8'h06, IO_PB3}, 8'h81, PB3_W));
    add(OP_PORT, '0, 8'd7, lcd_base({8'h03, IO_SBR}, 8'hC3, SBR_W));
    // Segments with RAMS set, then bank 0 ROM
    for (int i = 0; i < 4; i++) add(OP_WR, {8'h00, IO_SR0 + 8'(i)}, s[i], '0);
    add(OP_WR, {8'h00, IO_COM}, 8'h05, '0);
    for (int i = 0; i < 5; i++) begin
      add(OP_MRD, ma[i], 8'h00, translate(ma[i], s[0], s[1], s[2], s[3], 1'b1));
    end
    add(OP_WR, {8'h00, IO_COM}, 8'h01, '0);
    add(OP_MRD, 16'h0100, 8'h00, translate(16'h0100, s[0], s[1], s[2], s[3], 1'b0));
    // Keyboard rows from LFSR patterns
    for (int k = 0; k < 4; k++) begin
      lfsr_bits(km);
      add(OP_RD, {rows[k], IO_KBD}, 8'h00, kbd_rows(km, rows[k]), 1'b0, km);
      add(OP_PORT, '0, 8'd8, kbd_rows(km, 8'h00), 1'b0, km);
      add(OP_PORT, '0, 8'd9, paddr_t'(|km), 1'b0, km);
    end
    add(OP_PORT, '0, 8'd10, 22'd0); // Key status never sets
    add(OP_RD, {8'h00, IO_KBD}, 8'h00, 22'hFF);
    add(OP_PORT, '0, 8'd9, 22'd0);
    // RTC past one second, TIM0 in its upper half
    add(OP_WAIT, 16'd5400, 8'h00, '0);
    add(OP_TIM, {8'h00, IO_SR0}, 8'h00, '0);
    add(OP_TIM, {8'h00, IO_SR1}, 8'h00, '0);
    // Timer interrupt and acknowledge
    add(OP_WR, {8'h00, IO_TACK}, 8'h07, '0);
    add(OP_WR, {8'h00, IO_TMK}, 8'h01, '0);
    add(OP_WR, {8'h00, IO_INT}, 8'h03, '0);
    add(OP_WAIT, 16'd40, 8'h00, '0);
    add(OP_PORT, '0, 8'd1, 22'd0);
    add(OP_RD, {8'h00, IO_TSTA}, 8'h00, 22'h01);
    add(OP_WR, {8'h00, IO_COM}, 8'h10, '0); // RESTIM holds the RTC still
    add(OP_WR, {8'h00, IO_TACK}, 8'h07, '0);
    add(OP_WAIT, 16'd3, 8'h00, '0);
    add(OP_RD, {8'h00, IO_TSTA}, 8'h00, 22'h00);
    add(OP_PORT, '0, 8'd1, 22'd1);
    // Flap open, NMI and flap interrupt
    add(OP_WAIT, 16'd4, 8'h00, '0, 1'b1);
    add(OP_PORT, '0, 8'd2, 22'd0, 1'b1);
    add(OP_RD, {8'h00, IO_STA}, 8'h00, 22'hA0, 1'b1);
    add(OP_WR, {8'h00, IO_INT}, 8'h21, '0, 1'b1);
    add(OP_PORT, '0, 8'd1, 22'd0, 1'b1);
    add(OP_WR, {8'h00, IO_ACK}, 8'h20, '0);
    add(OP_WAIT, 16'd2, 8'h00, '0);
    add(OP_PORT, '0, 8'd1, 22'd1);
    add(OP_PORT, '0, 8'd2, 22'd1);
    add(OP_RD, {8'h00, IO_STA}, 8'h00, 22'h00);
  endtask

  task automatic apply_entry(input entry_t e);
    logic [4:0] cs;
    int ticks;
    paddr_t pv;
    @(posedge clk);
    #1;
    while (clk_ph !== 3'b001) begin // Start each access on phase 0
      @(posedge clk);
      #1;
    end
    kbmat = e.kbmat;
    flp = e.flp;
    z80_addr = e.addr;
    z80_wdata = e.data;
    case (e.op)
      OP_WR: begin
        z80_ior_n = 1'b0;
        z80_crd_n = 1'b1;
      end
      OP_RD, OP_TIM: begin
        z80_ior_n = 1'b0;
        z80_crd_n = 1'b0;
      end
      OP_MRD: begin
        z80_mrq_n = 1'b0;
        z80_crd_n = 1'b0;
      end
      default: ;
    endcase
    if (e.op == OP_WAIT) repeat (int'(e.addr)) @(posedge clk);
    else repeat (3) @(posedge clk);
    #1;
    case (e.op)
      OP_RD: check_data("z80_rdata", z80_rdata, e.exp[7:0]);
      OP_TIM: begin
        ticks = (rtc_edges - 1) / (TICK_DIV + 1); // Value before the read edge
        if (e.addr[7:0] == IO_SR0) check_data("tim0", z80_rdata, io_data_t'(ticks % 200));
        else check_data("tim1", z80_rdata, io_data_t'((ticks / 200) % 60));
        ticks = rtc_edges / (TICK_DIV + 1); // Counters after the read edge
        check_bit("t_1s", t_1s, ((ticks % 200) & 128) != 0);
        check_bit("t_5ms", t_5ms, ((rtc_edges % (TICK_DIV + 1)) & 2048) != 0);
      end
      OP_MRD: begin
        cs = cs_expect(e.exp);
        check_addr("ext_addr", ext_addr, e.exp);
        check_bit("ext_oe_n", ext_oe_n, 1'b0);
        check_bit("ext_we_n", ext_we_n, 1'b1);
        check_bit("rom_cs_n", rom_cs_n, cs[0]);
        check_bit("ram_cs_n", ram_cs_n, cs[1]);
        check_bit("ext_cs_n[1]", ext_cs_n[1], cs[2]);
        check_bit("ext_cs_n[2]", ext_cs_n[2], cs[3]);
        check_bit("ext_cs_n[3]", ext_cs_n[3], cs[4]);
      end
      OP_PORT: begin
        pv = port_value(e.data);
        if (e.data inside {8'd3, 8'd4, 8'd5, 8'd6, 8'd7, 8'd8}) begin
          check_addr(port_name(e.data), pv, e.exp);
        end else begin
          check_bit(port_name(e.data), pv[0], e.exp[0]);
        end
      end
      default: ;
    endcase
    z80_ior_n = 1'b1;
    z80_mrq_n = 1'b1;
    z80_crd_n = 1'b1;
    if (e.op == OP_MRD) begin
      @(posedge clk);
      #1;
      check_addr("ext_addr (lcd slot)", ext_addr, lcd_addr);
      check_bit("ext_oe_n (lcd slot)", ext_oe_n, 1'b0);
    end
  endtask

  // Watchdog sized from the table
  initial begin
    longint cycles;
    wait (table_ready);
    cycles = 100;
    foreach (tbl[i]) cycles += (tbl[i].op == OP_WAIT) ? tbl[i].addr + 8 : 8;
    #(cycles * 20);
    $display("Timeout: run did not finish within %0d cycles", cycles);
    $display("TB FAILED");
    $finish;
  end

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    flp = 1'b1;  // Open flap lets reset clear the RTC
    clk_ena = 1'b1;
    z80_hlt_n = 1'b1;
    z80_cm1_n = 1'b1;
    z80_crd_n = 1'b1;
    z80_mrq_n = 1'b1;
    z80_ior_n = 1'b1;
    z80_addr = '0;
    z80_wdata = '0;
    lcd_addr = LCD_ADDR;
    kbmat = '0;
    build_table();
    table_ready = 1;
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;
    flp = 1'b0;
    check_phase("clk_ph", clk_ph, 3'b001); // Reset phase
    @(posedge clk);
    #1;
    check_phase("clk_ph", clk_ph, 3'b010);
    @(posedge clk);
    #1;
    check_phase("clk_ph", clk_ph, 3'b100);
    foreach (tbl[i]) apply_entry(tbl[i]);
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

//--- vlog.f
rtl/blink_io_pkg.sv
rtl/blink_mem_pkg.sv
rtl/status_latch.sv
rtl/blink_mmu.sv
rtl/blink_regs.sv
rtl/rtc_timer.sv
rtl/int_ctrl.sv
rtl/kbd_matrix.sv
rtl/blink_top.sv
sim/tb_blink.sv
